// File: common/mbus_pkg.sv
/* Bus widths, protocol constants and the address word shared by the bus layer.
   Modules refer to these by scoped names. */
package mbus_pkg;

	localparam int addr_width = 8;
	localparam int data_width = 32;
	localparam int frame_bits = addr_width + data_width;	// bits after the start bit.
	localparam int func_width = 4;

	// upper nibble of a broadcast address.
	localparam logic [addr_width-func_width-1:0] bcast_prefix = 4'hF;

	// broadcast channel reserved for bus control traffic.
	localparam logic [func_width-1:0] channel_ctrl = 4'd0;

	localparam int bit_period = 4;	// CLK_EXT cycles per bit in master mode.

	// one address byte, read either as a broadcast or as a unicast address.
	typedef union packed {
		struct packed {
			logic [addr_width-func_width-1:0] prefix;	// bcast_prefix when broadcast.
			logic [func_width-1:0] channel;
		} bcast;
		struct packed {
			logic [addr_width-func_width-1:0] short_prefix;	// target node.
			logic [func_width-1:0] func_id;
		} ucast;
	} mbus_addr_u;

endpackage

// File: common/mbus_frame_if.sv
/* Received frame and its four-phase req/ack handshake, passed from the node
   receiver up to the layer. */
interface mbus_frame_if;

	mbus_pkg::mbus_addr_u addr;
	logic [mbus_pkg::data_width-1:0] data;
	logic broadcast;	// address carried the broadcast prefix.
	logic req;
	logic ack;

	// the receiver side presents the frame.
	modport node (
		output addr,
		output data,
		output broadcast,
		output req,
		input ack
	);

	// the consumer side takes it and acknowledges.
	modport layer (
		input addr,
		input data,
		input broadcast,
		input req,
		output ack
	);

endinterface

// File: mbus_ctrl/mbus_ctrl.sv
/* Master bus controller. It waits for a start bit on the ring and then issues
   the bit strobes for one frame. */
module mbus_ctrl (
	input logic CLK_EXT,
	input logic resetn,
	input logic din,
	output logic clkout,
	output logic dout
);

	logic active;	// a frame is being clocked.
	logic din_d;
	logic [1:0] period_cnt;
	logic [5:0] bit_cnt;	// strobes issued so far.

	always_ff @(posedge CLK_EXT or negedge resetn)
	begin
		if (!resetn)
		begin
			active <= 1'b0;
			din_d <= 1'b1;
			period_cnt <= 2'd0;
			bit_cnt <= 6'd0;
			clkout <= 1'b0;
		end
		else
		begin
			din_d <= din;
			clkout <= 1'b0;
			if (!active)
			begin
				// a falling edge on an idle line is a start bit.
				if (din_d && !din)
				begin
					active <= 1'b1;
					period_cnt <= 2'd1;	// the edge cycle counts as the first.
					bit_cnt <= 6'd0;
				end
			end
			else if (bit_cnt == 6'(mbus_pkg::frame_bits + 1))
				active <= 1'b0;	// the node has sampled the last strobe.
			else if (period_cnt == 2'(mbus_pkg::bit_period - 1))
			begin
				period_cnt <= 2'd0;
				clkout <= 1'b1;
				bit_cnt <= bit_cnt + 6'd1;
			end
			else
				period_cnt <= period_cnt + 2'd1;
		end
	end

	// the line is only passed on while a frame is clocked, which breaks the ring loop.
	assign dout = active ? din : 1'b1;

	strobe_single_cycle: assert property (@(posedge CLK_EXT) disable iff (!resetn)
		clkout |=> !clkout)
		else $error("bit strobe held for two cycles");

endmodule

// File: mbus_node/mbus_node_tx.sv
/* Frame transmitter. Shifts out start bit, address and data, one bit per strobe,
   then holds the stop level and pulses done. */
module mbus_node_tx (
	input logic CLK_EXT,
	input logic RESETn_local,
	input logic strobe,
	input logic start,
	input logic [mbus_pkg::addr_width-1:0] addr,
	input logic [mbus_pkg::data_width-1:0] data,
	output logic busy,
	output logic bit_out,
	output logic done
);

	logic stop_phase;	// last bit shifted, line at the stop level.
	logic [5:0] bit_cnt;
	logic [mbus_pkg::frame_bits:0] sreg;	// start bit on top.

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			busy <= 1'b0;
			stop_phase <= 1'b0;
			done <= 1'b0;
			bit_cnt <= 6'd0;
		end
		else
		begin
			done <= 1'b0;
			if (start && !busy)
			begin
				busy <= 1'b1;
				bit_cnt <= 6'd0;
			end
			else if (stop_phase)
			begin
				stop_phase <= 1'b0;
				busy <= 1'b0;
				done <= 1'b1;	// one cycle after the stop level went out.
			end
			else if (busy && strobe)
			begin
				bit_cnt <= bit_cnt + 6'd1;
				if (bit_cnt == 6'(mbus_pkg::frame_bits))
					stop_phase <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (start && !busy)
			sreg <= {1'b0, addr, data};
		else if (busy && strobe)
			sreg <= {sreg[mbus_pkg::frame_bits-1:0], 1'b1};	// ones fill in as the stop level.
	end

	assign bit_out = busy ? sreg[mbus_pkg::frame_bits] : 1'b1;

endmodule

// File: mbus_node/mbus_node_rx.sv
/* Frame receiver. Samples a frame on the bit strobes, decodes its address and
   hands frames meant for this node to the layer with req. */
module mbus_node_rx (
	input logic CLK_EXT,
	input logic RESETn_local,
	input logic strobe,
	input logic bit_in,
	input logic [mbus_pkg::addr_width-mbus_pkg::func_width-1:0] short_prefix,
	output logic busy,
	mbus_frame_if.node frame
);

	logic receiving;
	logic frame_done;	// sreg holds a complete frame this cycle.
	logic [5:0] bit_cnt;
	logic [mbus_pkg::frame_bits-1:0] sreg;
	mbus_pkg::mbus_addr_u rx_view;
	logic is_bcast;
	logic is_ucast;
	logic accept;

	assign rx_view = sreg[mbus_pkg::frame_bits-1 -: mbus_pkg::addr_width];
	assign is_bcast = (rx_view.bcast.prefix == mbus_pkg::bcast_prefix);
	assign is_ucast = (rx_view.ucast.short_prefix == short_prefix);

	// a frame is dropped while the previous one is still pending.
	assign accept = frame_done && (is_bcast || is_ucast) && !frame.req && !frame.ack;
	assign busy = receiving;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			receiving <= 1'b0;
			frame_done <= 1'b0;
			bit_cnt <= 6'd0;
			frame.req <= 1'b0;
			frame.broadcast <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			if (strobe)
			begin
				if (!receiving && !bit_in)
				begin
					receiving <= 1'b1;	// low on a strobe is a start bit.
					bit_cnt <= 6'd0;
				end
				else if (receiving)
				begin
					bit_cnt <= bit_cnt + 6'd1;
					if (bit_cnt == 6'(mbus_pkg::frame_bits - 1))
					begin
						receiving <= 1'b0;
						frame_done <= 1'b1;
					end
				end
			end

			if (frame.req && frame.ack)
				frame.req <= 1'b0;
			else if (accept)
			begin
				frame.req <= 1'b1;
				frame.broadcast <= is_bcast;
			end
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (strobe && receiving)
			sreg <= {sreg[mbus_pkg::frame_bits-2:0], bit_in};	// msb first.
		if (accept)
		begin
			frame.addr <= rx_view;
			frame.data <= sreg[mbus_pkg::data_width-1:0];
		end
	end

	ack_only_on_req: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		$rose(frame.ack) |-> frame.req)
		else $error("rx ack raised without a pending req");

endmodule

// File: mbus_node/mbus_node.sv
/* Bus node. Holds the transmitter and receiver, forwards the ring when idle and
   registers the line outputs. */
module mbus_node (
	input logic CLK_EXT,
	input logic RESETn_local,
	input logic clkin,
	input logic din,
	input logic [mbus_pkg::addr_width-mbus_pkg::func_width-1:0] short_prefix,
	input logic [mbus_pkg::addr_width-1:0] tx_addr,
	input logic [mbus_pkg::data_width-1:0] tx_data,
	input logic tx_req,
	output logic clkout,
	output logic dout,
	output logic tx_ack,
	mbus_frame_if.node frame
);

	logic tx_busy;
	logic tx_bit;
	logic tx_done;
	logic rx_busy;
	logic tx_hold;	// request already served, waiting for tx_req to drop.
	logic tx_start;

	// only start on a quiet line.
	assign tx_start = tx_req && !tx_hold && !tx_done && !rx_busy && din;
	assign tx_ack = tx_done;

	mbus_node_tx tx0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.strobe(clkin),
		.start(tx_start),
		.addr(tx_addr),
		.data(tx_data),
		.busy(tx_busy),
		.bit_out(tx_bit),
		.done(tx_done)
	);

	mbus_node_rx rx0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.strobe(clkin),
		.bit_in(din),
		.short_prefix(short_prefix),
		.busy(rx_busy),
		.frame(frame)
	);

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			dout <= 1'b1;	// line idles high.
			clkout <= 1'b0;
			tx_hold <= 1'b0;
		end
		else
		begin
			dout <= tx_busy ? tx_bit : din;
			clkout <= clkin;
			if (tx_done)
				tx_hold <= 1'b1;
			else if (!tx_req)
				tx_hold <= 1'b0;
		end
	end

endmodule

// File: logic/mbus_layer.sv
/* Bus layer top. Picks the master controller or the external ring as the node's
   source and, as master, absorbs control-channel broadcasts. */
module mbus_layer (
	input logic CLK_EXT,
	input logic RESETn_local,
	input logic master_en,
	input logic [mbus_pkg::addr_width-mbus_pkg::func_width-1:0] short_prefix,
	input logic clkin,
	input logic din,
	input logic [mbus_pkg::addr_width-1:0] tx_addr,
	input logic [mbus_pkg::data_width-1:0] tx_data,
	input logic tx_req,
	input logic rx_ack,
	output logic clkout,
	output logic dout,
	output logic tx_ack,
	output logic [mbus_pkg::addr_width-1:0] rx_addr,
	output logic [mbus_pkg::data_width-1:0] rx_data,
	output logic rx_req,
	output logic rx_broadcast
);

	mbus_frame_if frame ();

	logic ctrl_resetn;
	logic ctrl_clk;
	logic ctrl_dout;
	logic node_clkin;
	logic node_din;
	logic ctrl_match;	// pending frame is a bus control broadcast.
	logic ctrl_rx_ack;

	assign ctrl_resetn = RESETn_local & master_en;	// controller sleeps in slave mode.
	assign node_clkin = master_en ? ctrl_clk : clkin;
	assign node_din = master_en ? ctrl_dout : din;

	mbus_ctrl ctrl0 (
		.CLK_EXT(CLK_EXT),
		.resetn(ctrl_resetn),
		.din(din),
		.clkout(ctrl_clk),
		.dout(ctrl_dout)
	);

	mbus_node node0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.clkin(node_clkin),
		.din(node_din),
		.short_prefix(short_prefix),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_req(tx_req),
		.clkout(clkout),
		.dout(dout),
		.tx_ack(tx_ack),
		.frame(frame.node)
	);

	assign ctrl_match = frame.broadcast && (frame.addr.bcast.channel == mbus_pkg::channel_ctrl);

	// as master the layer consumes control broadcasts itself.
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
			ctrl_rx_ack <= 1'b0;
		else if (ctrl_rx_ack && !frame.req)
			ctrl_rx_ack <= 1'b0;	// node has dropped req.
		else if (master_en && ctrl_match && frame.req)
			ctrl_rx_ack <= 1'b1;
	end

	assign frame.ack = rx_ack | ctrl_rx_ack;
	assign rx_req = (master_en && ctrl_match) ? 1'b0 : frame.req;
	assign rx_addr = frame.addr;
	assign rx_data = frame.data;
	assign rx_broadcast = frame.broadcast;

	ctrl_bcast_absorbed: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		master_en && ctrl_match && frame.req |-> ##2 !frame.req)
		else $error("control broadcast was not absorbed in master mode");

endmodule

// File: tests/mbus_clk_gen.sv
/* Testbench clock and reset. CLK_EXT runs with a period of 8 and RESETn_local
   is held low for the first 2 cycles. */
module mbus_clk_gen (
	output logic CLK_EXT,
	output logic RESETn_local
);

	logic clk = 1'b0;

	always #4 clk = ~clk;
	assign CLK_EXT = clk;

	initial
	begin
		RESETn_local = 1'b0;
		repeat (2) @(posedge clk);
		#1 RESETn_local = 1'b1;	// released just after the second edge.
	end

endmodule

// File: tests/tb_cases.svh
/* Case table of the layer testbench, included into its top module. One row per
   add_case call: name, master mode, address, data, frame expected, rx_ack held. */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

string case_name[$];
bit case_master[$];
mbus_pkg::mbus_addr_u case_addr[$];
logic [mbus_pkg::data_width-1:0] case_data[$];
bit case_expect[$];
bit case_hold[$];	// rx_ack kept low for a while after rx_req.

function automatic mbus_pkg::mbus_addr_u ucast_addr(input logic [3:0] prefix,
	input logic [3:0] func);
	mbus_pkg::mbus_addr_u addr;
	addr.ucast.short_prefix = prefix;
	addr.ucast.func_id = func;
	return addr;
endfunction

function automatic mbus_pkg::mbus_addr_u bcast_addr(input logic [3:0] channel);
	mbus_pkg::mbus_addr_u addr;
	addr.bcast.prefix = 4'hF;	// broadcast prefix.
	addr.bcast.channel = channel;
	return addr;
endfunction

task automatic add_case(input string name, input bit master, input mbus_pkg::mbus_addr_u addr,
	input logic [31:0] data, input bit expect_frame, input bit hold_ack);
	case_name.push_back(name);
	case_master.push_back(master);
	case_addr.push_back(addr);
	case_data.push_back(data);
	case_expect.push_back(expect_frame);
	case_hold.push_back(hold_ack);
endtask

// the node's own prefix is 5, channel 0 carries bus control.
task automatic load_cases();
	add_case("master_unicast", 1'b1, ucast_addr(4'h5, 4'h3), $urandom(), 1'b1, 1'b0);
	add_case("master_ctrl_bcast", 1'b1, bcast_addr(4'h0), 32'h0000_00c1, 1'b0, 1'b0);
	add_case("master_bcast_ch2", 1'b1, bcast_addr(4'h2), $urandom(), 1'b1, 1'b0);
	add_case("master_ack_held", 1'b1, ucast_addr(4'h5, 4'h9), $urandom(), 1'b1, 1'b1);
	add_case("master_after_hold", 1'b1, ucast_addr(4'h5, 4'h1), 32'hdead_beef, 1'b1, 1'b0);
	add_case("slave_ctrl_bcast", 1'b0, bcast_addr(4'h0), $urandom(), 1'b1, 1'b0);
	add_case("slave_foreign", 1'b0, ucast_addr(4'ha, 4'h3), $urandom(), 1'b0, 1'b0);
	add_case("slave_ack_held", 1'b0, ucast_addr(4'h5, 4'h7), $urandom(), 1'b1, 1'b1);
	add_case("slave_after_hold", 1'b0, ucast_addr(4'h5, 4'he), 32'h8000_0001, 1'b1, 1'b0);
endtask

`endif

// File: tests/tb_mbus_layer.sv
/* Testbench for the bus layer. Runs the case table in master and slave mode and
   checks delivered frames, the handshakes and the line echo. */
module tb_mbus_layer;

	logic CLK_EXT;
	logic RESETn_local;
	logic master_en;
	logic [3:0] short_prefix;
	logic clkin;
	logic din;
	logic din_drv;	// line level driven in slave mode.
	logic [7:0] tx_addr;
	logic [31:0] tx_data;
	logic tx_req;
	logic rx_ack;
	logic clkout;
	logic dout;
	logic tx_ack;
	logic [7:0] rx_addr;
	logic [31:0] rx_data;
	logic rx_req;
	logic rx_broadcast;

	int error_count;
	int tx_ack_total;	// cycles with tx_ack high, counted on the falling edge.
	int rx_req_total;
	bit cases_loaded;
	int watchdog_limit;

	`include "tb_cases.svh"

	mbus_clk_gen clk_gen0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local)
	);

	mbus_layer dut0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.master_en(master_en),
		.short_prefix(short_prefix),
		.clkin(clkin),
		.din(din),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_req(tx_req),
		.rx_ack(rx_ack),
		.clkout(clkout),
		.dout(dout),
		.tx_ack(tx_ack),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.rx_req(rx_req),
		.rx_broadcast(rx_broadcast)
	);

	assign din = master_en ? dout : din_drv;	// the ring is closed in master mode.

	always @(negedge CLK_EXT)
	begin
		if (tx_ack)
			tx_ack_total++;
		if (rx_req)
			rx_req_total++;
	end

	task automatic check_value(input string test_name, input string field,
		input logic [63:0] expected, input logic [63:0] actual);
		begin
			assert (actual === expected)
			else
			begin
				$display("Fail %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
				error_count++;
			end
		end
	endtask

	task automatic wait_tx_ack(input string test_name);
		int cycles;
		begin
			cycles = 0;
			@(negedge CLK_EXT);
			while (tx_ack !== 1'b1 && cycles < 400)
			begin
				@(negedge CLK_EXT);
				cycles++;
			end
			assert (tx_ack === 1'b1)
			else
			begin
				$display("%s: tx_ack did not come within 400 cycles", test_name);
				error_count++;
			end
		end
	endtask

	task automatic wait_rx_req(input string test_name, input logic level);
		int cycles;
		begin
			cycles = 0;
			@(negedge CLK_EXT);
			while (rx_req !== level && cycles < 400)
			begin
				@(negedge CLK_EXT);
				cycles++;
			end
			assert (rx_req === level)
			else
			begin
				$display("%s: rx_req did not go to %0b within 400 cycles", test_name, level);
				error_count++;
			end
		end
	endtask

	// one bit every 4 cycles, strobe in the last of them, dout checked on the way.
	task automatic shift_frame(input string test_name, input logic [7:0] addr,
		input logic [31:0] data);
		logic [41:0] bits;
		int k;
		begin
			bits = {1'b0, addr, data, 1'b1};	// start, address, data, stop.
			for (k = 41; k >= 0; k--)
			begin
				din_drv = bits[k];
				clkin = 1'b0;
				repeat (2) @(posedge CLK_EXT);
				@(negedge CLK_EXT);
				check_value(test_name, "dout echo", 64'(bits[k]), 64'(dout));
				@(posedge CLK_EXT);
				#1 clkin = 1'b1;
				@(posedge CLK_EXT);
				#1;
			end
			clkin = 1'b0;
			din_drv = 1'b1;
		end
	endtask

	// the node's transmitter sends the frame as master, the din driver as slave.
	task automatic send_frame(input string test_name, input bit master,
		input logic [7:0] addr, input logic [31:0] data);
		begin
			if (master)
			begin
				tx_addr = addr;
				tx_data = data;
				tx_req = 1'b1;
				wait_tx_ack(test_name);
				@(posedge CLK_EXT);
				#1 tx_req = 1'b0;
			end
			else
				shift_frame(test_name, addr, data);
		end
	endtask

	task automatic run_case(input int i);
		int ack_before;
		int req_before;
		logic exp_bcast;
		begin
			exp_bcast = (case_addr[i].bcast.prefix == 4'hF);
			@(posedge CLK_EXT);
			#1 master_en = case_master[i];
			ack_before = tx_ack_total;
			req_before = rx_req_total;
			@(posedge CLK_EXT);
			#1;
			send_frame(case_name[i], case_master[i], case_addr[i], case_data[i]);
			if (case_expect[i])
			begin
				wait_rx_req(case_name[i], 1'b1);
				check_value(case_name[i], "rx_addr", 64'(case_addr[i]), 64'(rx_addr));
				check_value(case_name[i], "rx_data", 64'(case_data[i]), 64'(rx_data));
				check_value(case_name[i], "rx_broadcast", 64'(exp_bcast), 64'(rx_broadcast));
				if (case_hold[i])
				begin
					// a second frame for the node arrives while req is held and is dropped.
					@(posedge CLK_EXT);
					#1;
					send_frame(case_name[i], case_master[i], case_addr[i], ~case_data[i]);
					repeat (24)
					begin
						@(negedge CLK_EXT);
						check_value(case_name[i], "held rx_req", 64'(1), 64'(rx_req));
						check_value(case_name[i], "held rx_addr", 64'(case_addr[i]), 64'(rx_addr));
						check_value(case_name[i], "held rx_data", 64'(case_data[i]), 64'(rx_data));
					end
				end
				@(posedge CLK_EXT);
				#1 rx_ack = 1'b1;
				wait_rx_req(case_name[i], 1'b0);
				@(posedge CLK_EXT);
				#1 rx_ack = 1'b0;
			end
			else
			begin
				repeat (20) @(negedge CLK_EXT);
				check_value(case_name[i], "rx_req cycles", 64'(0), 64'(rx_req_total - req_before));
			end
			if (case_master[i])
				check_value(case_name[i], "tx_ack cycles", 64'(case_hold[i] ? 2 : 1),
					64'(tx_ack_total - ack_before));
		end
	endtask

	initial
	begin
		master_en = 1'b0;
		short_prefix = 4'h5;	// matches the unicast rows of the table.
		clkin = 1'b0;
		din_drv = 1'b1;
		tx_addr = 8'h00;
		tx_data = 32'h0;
		tx_req = 1'b0;
		rx_ack = 1'b0;
		void'($urandom(42));
		load_cases();
		cases_loaded = 1'b1;
		wait (RESETn_local === 1'b1);
		@(negedge CLK_EXT);
		check_value("reset", "dout", 64'(1), 64'(dout));
		check_value("reset", "clkout", 64'(0), 64'(clkout));
		check_value("reset", "tx_ack", 64'(0), 64'(tx_ack));
		check_value("reset", "rx_req", 64'(0), 64'(rx_req));
		foreach (case_name[i])
			run_case(i);
		repeat (4) @(negedge CLK_EXT);
		$display("%0d errors in %0d cases", error_count, case_name.size());
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// 500 cycles of 8 time units per case.
	initial
	begin
		wait (cases_loaded);
		watchdog_limit = case_name.size() * 500 * 8;
		#(watchdog_limit);
		$display("watchdog expired after %0d time units, the run did not finish", watchdog_limit);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+tests
common/mbus_pkg.sv
common/mbus_frame_if.sv
mbus_ctrl/mbus_ctrl.sv
mbus_node/mbus_node_tx.sv
mbus_node/mbus_node_rx.sv
mbus_node/mbus_node.sv
logic/mbus_layer.sv
tests/mbus_clk_gen.sv
tests/tb_mbus_layer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bus layer testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
	&& verilator --binary --assert --top-module tb_mbus_layer -f vlog.f -o tb_mbus_layer \
	&& ./obj_dir/tb_mbus_layer | tee sim.log \
	&& grep -q "All tests passed" sim.log \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }
